// File: rtl/dwc_macros.svh
// Read downsizer width macros for the wide and narrow AXI read ports

`ifndef DWC_MACROS_SVH
`define DWC_MACROS_SVH

// Address and transaction ID widths
`define DWC_ADDR_W 32
`define DWC_ID_W 4

// Upstream data width
`define DWC_WIDE_DATA_W 64

// Downstream data width
`define DWC_NARROW_DATA_W 32

// Bytes per beat on each side
`define DWC_WIDE_BYTES (`DWC_WIDE_DATA_W / 8)
`define DWC_NARROW_BYTES (`DWC_NARROW_DATA_W / 8)

// AXI size code of a full narrow beat
`define DWC_NARROW_SIZE $clog2(`DWC_NARROW_BYTES)

`endif

// File: rtl/axi_chan_pkg.sv
// AXI read channel types shared by the wide and narrow ports of the downsizer
`default_nettype none

`include "dwc_macros.svh"

package axi_chan_pkg;

  // Field types
  typedef logic [`DWC_ADDR_W-1:0] addr_t;
  typedef logic [`DWC_ID_W-1:0]   id_t;
  typedef logic [7:0]             len_t;
  typedef logic [2:0]             size_t;
  typedef logic [1:0]             burst_t;
  typedef logic [3:0]             cache_t;
  typedef logic [1:0]             resp_t;

  typedef logic [`DWC_WIDE_DATA_W-1:0]   wide_data_t;
  typedef logic [`DWC_NARROW_DATA_W-1:0] narrow_data_t;

  // Burst encodings
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

  // Cache bit 1 allows the interconnect to reshape the burst
  localparam cache_t CACHE_MODIFIABLE = 4'b0010;

  // Response encodings
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Read address channel, same layout on both ports
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } ar_chan_t;

  // Read data channel of the wide port
  typedef struct packed {
    id_t        id;
    wide_data_t data;
    resp_t      resp;
    logic       last;
  } wide_r_chan_t;

  // Read data channel of the narrow port
  typedef struct packed {
    id_t          id;
    narrow_data_t data;
    resp_t        resp;
    logic         last;
  } narrow_r_chan_t;

endpackage

`default_nettype wire

// File: rtl/dwc_read_pkg.sv
// Read downsizer internal command, beat and mode types with address helpers
`default_nettype none

package dwc_read_pkg;

  import axi_chan_pkg::*;

  // Execute state, also carried with each command
  typedef enum logic [1:0] {
    MODE_IDLE,
    MODE_PASS,
    MODE_DOWNSIZE,
    MODE_ERROR
  } dwc_mode_e;

  // Decoded request handed from decode to execute
  typedef struct packed {
    ar_chan_t  ar;
    addr_t     orig_addr;
    size_t     orig_size;
    len_t      orig_len;
    dwc_mode_e mode;
  } read_cmd_t;

  // State of the wide beat currently being answered
  typedef struct packed {
    id_t       id;
    addr_t     addr;
    size_t     size;
    logic      last;
    dwc_mode_e mode;
  } beat_info_t;

  // Clear the address bits below the given size
  function automatic addr_t align_addr(addr_t addr, size_t size);
    addr_t mask;
    mask = (addr_t'(1) << size) - addr_t'(1);
    return addr & ~mask;
  endfunction

  // Address of the following beat of an INCR burst
  function automatic addr_t next_beat_addr(addr_t addr, size_t size);
    return align_addr(addr, size) + (addr_t'(1) << size);
  endfunction

endpackage

`default_nettype wire

// File: rtl/dwc_ar_decode.sv
// AR decode stage that classifies wide read requests and computes the narrow burst
`default_nettype none

`include "dwc_macros.svh"

module dwc_ar_decode
  import axi_chan_pkg::*;
  import dwc_read_pkg::*;
(
  input  ar_chan_t  wide_ar_i,
  input  logic      wide_ar_valid_i,
  output logic      wide_ar_ready_o,
  input  logic      exec_idle_i,
  output read_cmd_t cmd_o,
  output logic      cmd_valid_o
);

  localparam size_t narrow_size = size_t'(`DWC_NARROW_SIZE);

  addr_t start_addr;
  addr_t end_addr;
  addr_t burst_span;
  logic  modifiable;

  // One transaction at a time, so accept only while execute is idle
  assign wide_ar_ready_o = exec_idle_i;
  assign cmd_valid_o     = wide_ar_valid_i & wide_ar_ready_o;

  assign modifiable = |(wide_ar_i.cache & CACHE_MODIFIABLE);

  // Narrow words touched by the burst, from first byte to last beat start
  assign burst_span = addr_t'(wide_ar_i.len) << wide_ar_i.size;
  assign start_addr = align_addr(wide_ar_i.addr, narrow_size);
  assign end_addr   = align_addr(align_addr(wide_ar_i.addr, wide_ar_i.size) + burst_span,
                                 narrow_size);

  always_comb begin
    cmd_o.ar        = wide_ar_i;
    cmd_o.orig_addr = wide_ar_i.addr;
    cmd_o.orig_size = wide_ar_i.size;
    cmd_o.orig_len  = wide_ar_i.len;
    cmd_o.mode      = MODE_PASS;

    if (wide_ar_i.size > narrow_size) begin
      // Beats wider than the narrow port are not split
      cmd_o.mode = MODE_ERROR;
    end else begin
      case (wide_ar_i.burst)
        BURST_INCR: begin
          if (modifiable) begin
            // Repack into full narrow beats
            cmd_o.mode    = MODE_DOWNSIZE;
            cmd_o.ar.len  = len_t'((end_addr - start_addr) >> narrow_size);
            cmd_o.ar.size = narrow_size;
          end
        end
        BURST_WRAP, BURST_FIXED: begin
          // Only a single narrow beat can be forwarded unchanged
          if (wide_ar_i.len != '0) begin
            cmd_o.mode = MODE_ERROR;
          end
        end
        default: begin
          cmd_o.mode = MODE_ERROR;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/dwc_ar_execute.sv
// AR execute stage that issues the narrow AR and tracks the wide beat position
`default_nettype none

module dwc_ar_execute
  import axi_chan_pkg::*;
  import dwc_read_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  read_cmd_t  cmd_i,
  input  logic       cmd_valid_i,
  output logic       exec_idle_o,
  output ar_chan_t   narrow_ar_o,
  output logic       narrow_ar_valid_o,
  input  logic       narrow_ar_ready_i,
  output beat_info_t beat_o,
  output logic       beat_active_o,
  input  logic       beat_done_i
);

  dwc_mode_e mode_q;
  logic      ar_valid_q;
  ar_chan_t  ar_q;
  addr_t     addr_q;
  size_t     size_q;
  len_t      cnt_q;

  assign exec_idle_o   = (mode_q == MODE_IDLE);
  assign beat_active_o = (mode_q != MODE_IDLE);

  assign narrow_ar_o       = ar_q;
  assign narrow_ar_valid_o = ar_valid_q;

  // Beat view for the result stage
  assign beat_o.id   = ar_q.id;
  assign beat_o.addr = addr_q;
  assign beat_o.size = size_q;
  assign beat_o.last = (cnt_q == '0);
  assign beat_o.mode = mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= MODE_IDLE;
      ar_valid_q <= 1'b0;
    end else begin
      if (cmd_valid_i) begin
        mode_q <= cmd_i.mode;
        // Error bursts are answered locally without a narrow request
        ar_valid_q <= (cmd_i.mode != MODE_ERROR);
      end else begin
        if (narrow_ar_valid_o && narrow_ar_ready_i) begin
          ar_valid_q <= 1'b0;
        end
        if (beat_done_i && beat_o.last) begin
          mode_q <= MODE_IDLE;
        end
      end
    end
  end

  // Request and position of the running burst
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      ar_q   <= cmd_i.ar;
      addr_q <= cmd_i.orig_addr;
      size_q <= cmd_i.orig_size;
      cnt_q  <= cmd_i.orig_len;
    end else if (beat_done_i) begin
      addr_q <= next_beat_addr(addr_q, size_q);
      cnt_q  <= cnt_q - len_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: rtl/dwc_r_result.sv
// R result stage that steers narrow beats onto wide lanes or answers with SLVERR
`default_nettype none

`include "dwc_macros.svh"

module dwc_r_result
  import axi_chan_pkg::*;
  import dwc_read_pkg::*;
(
  input  beat_info_t     beat_i,
  input  logic           beat_active_i,
  output logic           beat_done_o,
  input  narrow_r_chan_t narrow_r_i,
  input  logic           narrow_r_valid_i,
  output logic           narrow_r_ready_o,
  output wide_r_chan_t   wide_r_o,
  output logic           wide_r_valid_o,
  input  logic           wide_r_ready_i
);

  localparam size_t narrow_size = size_t'(`DWC_NARROW_SIZE);

  logic [narrow_size-1:0] narrow_off;
  logic [2:0]             wide_off;
  logic                   word_done;
  wide_data_t             steered_data;

  // Byte offsets of the current beat within each port's word
  assign narrow_off = beat_i.addr[narrow_size-1:0];
  assign wide_off   = beat_i.addr[2:0];

  // The following beat moves on to another narrow word
  assign word_done = beat_i.last ||
                     (align_addr(next_beat_addr(beat_i.addr, beat_i.size), narrow_size) !=
                      align_addr(beat_i.addr, narrow_size));

  // Lane steering of the beat bytes, everything else stays zero
  always_comb begin
    steered_data = '0;
    for (int b = 0; b < `DWC_NARROW_BYTES; b++) begin
      if ((b >= int'(narrow_off)) &&
          (b - int'(narrow_off) < (1 << beat_i.size)) &&
          (b + int'(wide_off) - int'(narrow_off) < `DWC_WIDE_BYTES)) begin
        steered_data[8*(b + int'(wide_off) - int'(narrow_off)) +: 8] = narrow_r_i.data[8*b +: 8];
      end
    end
  end

  always_comb begin
    wide_r_o         = '0;
    wide_r_valid_o   = 1'b0;
    narrow_r_ready_o = 1'b0;

    if (beat_active_i) begin
      case (beat_i.mode)
        MODE_PASS: begin
          wide_r_o.id      = narrow_r_i.id;
          wide_r_o.data    = steered_data;
          wide_r_o.resp    = narrow_r_i.resp;
          wide_r_o.last    = beat_i.last;
          wide_r_valid_o   = narrow_r_valid_i;
          narrow_r_ready_o = wide_r_ready_i;
        end
        MODE_DOWNSIZE: begin
          wide_r_o.id    = narrow_r_i.id;
          wide_r_o.data  = steered_data;
          wide_r_o.resp  = narrow_r_i.resp;
          wide_r_o.last  = beat_i.last;
          wide_r_valid_o = narrow_r_valid_i;
          // Keep the narrow word for the next small wide beats
          narrow_r_ready_o = wide_r_ready_i & word_done;
        end
        MODE_ERROR: begin
          wide_r_o.id    = beat_i.id;
          wide_r_o.resp  = RESP_SLVERR;
          wide_r_o.last  = beat_i.last;
          wide_r_valid_o = 1'b1;
        end
        default: begin
          wide_r_valid_o = 1'b0;
        end
      endcase
    end
  end

  assign beat_done_o = wide_r_valid_o & wide_r_ready_i;

endmodule

`default_nettype wire

// File: rtl/axi_dw_read_downsizer.sv
// AXI read downsizer top level bridging a 64-bit read port onto a 32-bit port
`default_nettype none

module axi_dw_read_downsizer
  import axi_chan_pkg::*;
  import dwc_read_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  // Wide side, towards the master
  input  ar_chan_t       wide_ar_i,
  input  logic           wide_ar_valid_i,
  output logic           wide_ar_ready_o,
  output wide_r_chan_t   wide_r_o,
  output logic           wide_r_valid_o,
  input  logic           wide_r_ready_i,
  // Narrow side, towards the slave
  output ar_chan_t       narrow_ar_o,
  output logic           narrow_ar_valid_o,
  input  logic           narrow_ar_ready_i,
  input  narrow_r_chan_t narrow_r_i,
  input  logic           narrow_r_valid_i,
  output logic           narrow_r_ready_o
);

  read_cmd_t  cmd;
  logic       cmd_valid;
  logic       exec_idle;
  beat_info_t beat;
  logic       beat_active;
  logic       beat_done;

  dwc_ar_decode i_ar_decode (
    .wide_ar_i       (wide_ar_i),
    .wide_ar_valid_i (wide_ar_valid_i),
    .wide_ar_ready_o (wide_ar_ready_o),
    .exec_idle_i     (exec_idle),
    .cmd_o           (cmd),
    .cmd_valid_o     (cmd_valid)
  );

  dwc_ar_execute i_ar_execute (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cmd_i             (cmd),
    .cmd_valid_i       (cmd_valid),
    .exec_idle_o       (exec_idle),
    .narrow_ar_o       (narrow_ar_o),
    .narrow_ar_valid_o (narrow_ar_valid_o),
    .narrow_ar_ready_i (narrow_ar_ready_i),
    .beat_o            (beat),
    .beat_active_o     (beat_active),
    .beat_done_i       (beat_done)
  );

  dwc_r_result i_r_result (
    .beat_i           (beat),
    .beat_active_i    (beat_active),
    .beat_done_o      (beat_done),
    .narrow_r_i       (narrow_r_i),
    .narrow_r_valid_i (narrow_r_valid_i),
    .narrow_r_ready_o (narrow_r_ready_o),
    .wide_r_o         (wide_r_o),
    .wide_r_valid_o   (wide_r_valid_o),
    .wide_r_ready_i   (wide_r_ready_i)
  );

endmodule

`default_nettype wire

// File: testbench/tb_narrow_mem.sv
// Narrow AXI read slave model that answers bursts from a byte memory
`default_nettype none

module tb_narrow_mem
  import axi_chan_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ar_chan_t       ar_i,
  input  logic           ar_valid_i,
  output logic           ar_ready_o,
  output narrow_r_chan_t r_o,
  output logic           r_valid_o,
  input  logic           r_ready_i,
  output int             ar_count_o,
  output len_t           last_len_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_BYTES = 8192;

  logic [7:0] mem [MEM_BYTES];
  ar_chan_t   cur_ar;
  logic       busy;
  int         beat;

  // Whole aligned narrow word around the given address
  function automatic narrow_data_t read_word(addr_t addr);
    narrow_data_t word;
    addr_t        base;
    base = addr & ~addr_t'(3);
    for (int j = 0; j < 4; j++) begin
      word[8*j +: 8] = mem[(base + addr_t'(j)) % MEM_BYTES];
    end
    return word;
  endfunction

  initial begin
    for (int k = 0; k < MEM_BYTES; k++) begin
      mem[k] = 8'(k * 7 + 3);
    end
    ar_ready_o = 1'b0;
    r_o        = '0;
    r_valid_o  = 1'b0;
    ar_count_o = 0;
    last_len_o = '0;
    cur_ar     = '0;
    busy       = 1'b0;
    beat       = 0;
  end

  always @(posedge clk_i) begin
    logic     ar_fire;
    logic     r_fire;
    ar_chan_t ar_in;
    addr_t    step;
    ar_fire = ar_valid_i && ar_ready_o;
    r_fire  = r_valid_o && r_ready_i;
    ar_in   = ar_i;
    #1;
    if (!rst_ni) begin
      busy       = 1'b0;
      ar_ready_o = 1'b0;
      r_valid_o  = 1'b0;
    end else begin
      if (ar_fire) begin
        cur_ar     = ar_in;
        busy       = 1'b1;
        beat       = 0;
        ar_count_o = ar_count_o + 1;
        last_len_o = ar_in.len;
      end
      if (r_fire) begin
        r_valid_o = 1'b0;
        if (beat == int'(cur_ar.len)) begin
          busy = 1'b0;
        end else begin
          beat = beat + 1;
        end
      end
      ar_ready_o = !busy;
      // Present the next beat, leaving a random gap now and then
      if (busy && !r_valid_o && ($urandom_range(0, 3) != 0)) begin
        step      = addr_t'(1) << cur_ar.size;
        r_o.id    = cur_ar.id;
        r_o.data  = read_word((cur_ar.addr & ~(step - 1)) + addr_t'(beat) * step);
        r_o.resp  = RESP_OKAY;
        r_o.last  = (beat == int'(cur_ar.len));
        r_valid_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_axi_dw_read_downsizer.sv
// Testbench for the AXI read downsizer with a narrow memory model and a reference check
`default_nettype none

module tb_axi_dw_read_downsizer
  import axi_chan_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RANDOM_BURSTS  = 30;

  logic           clk;
  logic           rst_n;
  ar_chan_t       wide_ar;
  logic           wide_ar_valid;
  logic           wide_ar_ready;
  wide_r_chan_t   wide_r;
  logic           wide_r_valid;
  logic           wide_r_ready;
  ar_chan_t       narrow_ar;
  logic           narrow_ar_valid;
  logic           narrow_ar_ready;
  narrow_r_chan_t narrow_r;
  logic           narrow_r_valid;
  logic           narrow_r_ready;
  int             mem_ar_count;
  len_t           mem_last_len;

  ar_chan_t open_q[$];
  string    test_name;
  int       beat_idx;
  int       sent_count;
  int       done_count;
  int       cycles;

  axi_dw_read_downsizer axi_dw_read_downsizer_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .wide_ar_i         (wide_ar),
    .wide_ar_valid_i   (wide_ar_valid),
    .wide_ar_ready_o   (wide_ar_ready),
    .wide_r_o          (wide_r),
    .wide_r_valid_o    (wide_r_valid),
    .wide_r_ready_i    (wide_r_ready),
    .narrow_ar_o       (narrow_ar),
    .narrow_ar_valid_o (narrow_ar_valid),
    .narrow_ar_ready_i (narrow_ar_ready),
    .narrow_r_i        (narrow_r),
    .narrow_r_valid_i  (narrow_r_valid),
    .narrow_r_ready_o  (narrow_r_ready)
  );

  tb_narrow_mem narrow_mem_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .ar_i       (narrow_ar),
    .ar_valid_i (narrow_ar_valid),
    .ar_ready_o (narrow_ar_ready),
    .r_o        (narrow_r),
    .r_valid_o  (narrow_r_valid),
    .r_ready_i  (narrow_r_ready),
    .ar_count_o (mem_ar_count),
    .last_len_o (mem_last_len)
  );

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  task automatic check_failed(string msg);
    $display("ERROR in test %s: %s", test_name, msg);
    stop_run();
  endtask

  task automatic report_mismatch(string what, logic [63:0] exp, logic [63:0] act);
    $display("MISMATCH test=%s field=%s expected=%0h actual=%0h", test_name, what, exp, act);
    stop_run();
  endtask

  // Memory content rule of the narrow slave
  function automatic logic [7:0] mem_byte(addr_t a);
    return 8'(a * 7 + 3);
  endfunction

  function automatic bit is_error(ar_chan_t ar);
    return (ar.size > 3'd2) || ((ar.burst != BURST_INCR) && (ar.len != '0));
  endfunction

  function automatic bit is_downsize(ar_chan_t ar);
    return !is_error(ar) && (ar.burst == BURST_INCR) && ar.cache[1];
  endfunction

  // Start address aligned to the size plus i beats
  function automatic addr_t beat_addr(ar_chan_t ar, int i);
    addr_t step;
    step = addr_t'(1) << ar.size;
    return (ar.addr & ~(step - 1)) + addr_t'(i) * step;
  endfunction

  function automatic wide_data_t expected_data(addr_t a, size_t size);
    wide_data_t d;
    addr_t      b;
    d = '0;
    for (int j = 0; j < (1 << size); j++) begin
      b = a + addr_t'(j);
      if (b[31:2] == a[31:2]) begin
        d[8*b[2:0] +: 8] = mem_byte(b);
      end
    end
    return d;
  endfunction

  // Downsized bursts span narrow words from the first byte to the last beat
  function automatic len_t expected_narrow_len(ar_chan_t ar);
    if (is_downsize(ar)) begin
      return len_t'((beat_addr(ar, int'(ar.len)) >> 2) - (ar.addr >> 2));
    end
    return ar.len;
  endfunction

  function automatic ar_chan_t random_ar();
    ar_chan_t ar;
    int       kind;
    kind     = $urandom_range(0, 4);
    ar.id    = id_t'($urandom);
    ar.len   = len_t'($urandom_range(0, 15));
    ar.size  = size_t'($urandom_range(0, 2));
    ar.burst = BURST_INCR;
    ar.cache = 4'h0;
    case (kind)
      1: ar.cache = 4'h2;
      2: begin
        ar.burst = BURST_WRAP;
        ar.len   = len_t'((2 << $urandom_range(0, 3)) - 1);
      end
      3: ar.size = 3'd3;
      4: begin
        ar.burst = BURST_FIXED;
        ar.len   = '0;
      end
      default: ar.cache = 4'h0;
    endcase
    ar.addr = addr_t'($urandom_range(0, 4095)) & ~((addr_t'(1) << ar.size) - 1);
    return ar;
  endfunction

  // Called 1 ns after an edge and returns 1 ns after the handshake edge
  task automatic send_ar(ar_chan_t ar);
    wide_ar       = ar;
    wide_ar_valid = 1'b1;
    while (!wide_ar_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    wide_ar_valid = 1'b0;
    sent_count    = sent_count + 1;
  endtask

  task automatic wait_done();
    do begin
      @(posedge clk);
      #1;
    end while (done_count != sent_count);
  endtask

  task automatic run_directed(string name, ar_chan_t ar, int exp_ars);
    int ars_before;
    test_name  = name;
    ars_before = mem_ar_count;
    send_ar(ar);
    wait_done();
    assert (mem_ar_count - ars_before == exp_ars)
      else report_mismatch("narrow AR count", exp_ars, mem_ar_count - ars_before);
    if (exp_ars > 0) begin
      assert (mem_last_len == expected_narrow_len(ar))
        else report_mismatch("narrow AR len", expected_narrow_len(ar), mem_last_len);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      check_failed("timeout, the tests did not finish within the cycle limit");
    end
  end

  // Random wide R back-pressure
  always @(posedge clk) begin
    #1 wide_r_ready = rst_n && ($urandom_range(0, 3) != 0);
  end

  // Checks on every transfer
  always @(posedge clk) begin
    ar_chan_t   cur;
    wide_data_t exp_data;
    resp_t      exp_resp;
    size_t      exp_size;
    if (rst_n) begin
      if (narrow_ar_valid && narrow_ar_ready) begin
        assert ((open_q.size() != 0) && !is_error(open_q[0]))
          else check_failed("narrow AR issued without a forwardable transaction");
        assert (narrow_ar.len == expected_narrow_len(open_q[0]))
          else report_mismatch("narrow len", expected_narrow_len(open_q[0]), narrow_ar.len);
        // Downsized bursts use full narrow beats
        exp_size = is_downsize(open_q[0]) ? size_t'(2) : open_q[0].size;
        assert (narrow_ar.size == exp_size)
          else report_mismatch("narrow size", exp_size, narrow_ar.size);
      end
      if (wide_r_valid && wide_r_ready) begin
        assert (open_q.size() != 0) else check_failed("wide R beat with no open transaction");
        cur = open_q[0];
        exp_data = '0;
        exp_resp = RESP_SLVERR;
        if (!is_error(cur)) begin
          exp_data = expected_data(beat_addr(cur, beat_idx), cur.size);
          exp_resp = RESP_OKAY;
        end
        assert (wide_r.id == cur.id) else report_mismatch("id", cur.id, wide_r.id);
        assert (wide_r.data == exp_data) else report_mismatch("data", exp_data, wide_r.data);
        assert (wide_r.resp == exp_resp) else report_mismatch("resp", exp_resp, wide_r.resp);
        assert (wide_r.last == (beat_idx == int'(cur.len)))
          else report_mismatch("last", beat_idx == int'(cur.len), wide_r.last);
        if (wide_r.last) begin
          void'(open_q.pop_front());
          done_count = done_count + 1;
        end else begin
          beat_idx = beat_idx + 1;
        end
      end
      if (wide_ar_valid && wide_ar_ready) begin
        assert (open_q.size() == 0) else check_failed("wide AR accepted during an open transaction");
        open_q.push_back(wide_ar);
        beat_idx = 0;
      end
    end
  end

  initial begin
    void'($urandom(32'hc6eab2f1));
    test_name     = "reset";
    rst_n         = 1'b0;
    wide_ar       = '0;
    wide_ar_valid = 1'b0;
    wide_r_ready  = 1'b0;
    sent_count    = 0;
    done_count    = 0;
    cycles        = 0;
    beat_idx      = 0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    assert (wide_ar_ready && !narrow_ar_valid && !wide_r_valid && !narrow_r_ready)
      else check_failed("outputs are not in their reset state");

    run_directed("pass_through", '{4'h1, 32'h0000_0104, 8'd3, 3'd2, BURST_INCR, 4'h0}, 1);
    run_directed("downsize_pack", '{4'h2, 32'h0000_0201, 8'd7, 3'd0, BURST_INCR, 4'h2}, 1);
    run_directed("slverr_wrap", '{4'h3, 32'h0000_0040, 8'd3, 3'd2, BURST_WRAP, 4'h0}, 0);
    run_directed("slverr_size3", '{4'h4, 32'h0000_0080, 8'd2, 3'd3, BURST_INCR, 4'h2}, 0);
    run_directed("fixed_single", '{4'h5, 32'h0000_0302, 8'd0, 3'd1, BURST_FIXED, 4'h0}, 1);

    // Back to back requests where the next one waits while the previous is open
    test_name = "random_mix";
    for (int n = 0; n < RANDOM_BURSTS; n++) begin
      send_ar(random_ar());
    end
    wait_done();

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/axi_chan_pkg.sv
rtl/dwc_read_pkg.sv
rtl/dwc_ar_decode.sv
rtl/dwc_ar_execute.sv
rtl/dwc_r_result.sv
rtl/axi_dw_read_downsizer.sv
testbench/tb_narrow_mem.sv
testbench/tb_axi_dw_read_downsizer.sv

// File: Bender.yml
package:
  name: axi_dw_read_downsizer

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/axi_chan_pkg.sv
      - rtl/dwc_read_pkg.sv
      - rtl/dwc_ar_decode.sv
      - rtl/dwc_ar_execute.sv
      - rtl/dwc_r_result.sv
      - rtl/axi_dw_read_downsizer.sv
  - target: test
    files:
      - testbench/tb_narrow_mem.sv
      - testbench/tb_axi_dw_read_downsizer.sv
